//--- project.f
verilog/saturn_bus_pkg.sv
verilog/saturn_core_pkg.sv
verilog/saturn_bus_phase.sv
verilog/saturn_cmd_seq.sv
verilog/saturn_addr_loop.sv
verilog/saturn_data_xfer.sv
verilog/saturn_bus_arbiter.sv
verilog/saturn_bus_ctrl.sv
verif/tb_saturn_bus_ctrl.sv

//--- Makefile
# Verilator build and run for the saturn bus controller testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_saturn_bus_ctrl -Mdir obj_dir
	./obj_dir/Vtb_saturn_bus_ctrl | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_saturn_bus_ctrl.sv
// testbench for the saturn bus controller with a strobe logging bus model and assertions
`timescale 1ns/100ps
`default_nettype none

module tb_saturn_bus_ctrl
  import saturn_bus_pkg::*, saturn_core_pkg::*;
;

  // startup, load_pc, reads, busy hold, load_dp, dp write, configure, idle gaps
  localparam int TOTAL_SLOTS = 60;
  localparam int CYCLE_LIMIT = 4 * TOTAL_SLOTS + 200;
  localparam logic [31:0] TAPS = 32'h8020_0003;

  logic i_clk = 1'b0;
  logic cmd_RESET_0;
  core_req_t req_ctl;
  core_req_t req_bus;
  logic [3:0] wr_nibl;
  logic i_alu_busy;
  logic [3:0] i_bus_data;
  logic [3:0] o_bus_data;
  logic o_bus_cmd_data;
  logic o_bus_strobe;
  logic o_bus_reset;
  logic [3:0] o_nibble;
  logic [CNT_W-1:0] o_data_ptr;
  logic o_stall_alu;
  logic o_bus_done;

  // strobe log of the bus model
  logic [3:0] words[$];
  logic cds[$];
  time stimes[$];
  int startup_strobes = 0;
  int done_cnt = 0;
  int done_at = -1;
  logic [31:0] stim_lfsr = 32'h225d;
  logic [31:0] bus_lfsr = 32'h225d;
  logic [3:0] wr_data[8];
  logic read_ctx = 1'b0;
  logic busy_hold = 1'b0;
  logic cfg_window = 1'b0;
  logic rd_chk = 1'b0;
  logic [3:0] rd_exp = '0;
  int cycles = 0;

  always #5 i_clk = ~i_clk;

  // core model presents the write nibble for the current pointer
  always_comb begin
    req_bus = req_ctl;
    req_bus.data_nibl = wr_nibl;
  end

  saturn_bus_ctrl dut_i (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_req          (req_bus),
    .i_alu_busy     (i_alu_busy),
    .i_bus_data     (i_bus_data),
    .o_bus_data     (o_bus_data),
    .o_bus_cmd_data (o_bus_cmd_data),
    .o_bus_strobe   (o_bus_strobe),
    .o_bus_reset    (o_bus_reset),
    .o_nibble       (o_nibble),
    .o_data_ptr     (o_data_ptr),
    .o_stall_alu    (o_stall_alu),
    .o_bus_done     (o_bus_done)
  );

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // one galois lfsr step
  function automatic logic [31:0] lfsr_step(input logic [31:0] st);
    return st[0] ? ((st >> 1) ^ TAPS) : (st >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = st[0];
      st = lfsr_step(st);
    end
  endtask

  task automatic wait_strobes(input int n);
    while (words.size() < n) begin
      @(posedge i_clk);
    end
  endtask

  task automatic check_word(input int idx, input logic [3:0] w, input logic cd);
    assert (words[idx] == w && cds[idx] == cd)
    else report_error($sformatf("strobe %0d at %0t: word %h cd %b, expected %h cd %b",
                                idx, stimes[idx], words[idx], cds[idx], w, cd));
  endtask

  task automatic clear_log();
    words.delete();
    cds.delete();
    stimes.delete();
  endtask

  // address command with five nibbles low first and an optional PC_READ after
  task automatic run_addr_cmd(input bus_cmd_e code, input logic [19:0] addr,
                              input logic pc_read_after);
    int n;
    n = pc_read_after ? 7 : 6;
    clear_log();
    req_ctl.address <= addr;
    req_ctl.load_pc <= (code == LOAD_PC);
    req_ctl.load_dp <= (code == LOAD_DP);
    req_ctl.configure <= (code == CONFIGURE);
    wait_strobes(1);
    req_ctl.load_pc <= 1'b0;
    req_ctl.load_dp <= 1'b0;
    req_ctl.configure <= 1'b0;
    wait_strobes(n);
    check_word(0, code, 1'b0);
    for (int k = 0; k < 5; k++) begin
      check_word(k + 1, addr[4*k +: 4], 1'b1);
    end
    if (pc_read_after) begin
      check_word(6, PC_READ, 1'b0);
    end
    repeat (3) @(posedge i_clk);
    assert (!o_stall_alu) else report_error("stall still high after address command");
  endtask

  // bus model logs every strobe and drives fresh read data between strobes
  always @(posedge i_clk) begin
    logic [31:0] v;
    rd_chk <= 1'b0;
    if (o_bus_strobe) begin
      words.push_back(o_bus_data);
      cds.push_back(o_bus_cmd_data);
      stimes.push_back($time);
      if (o_bus_reset) begin
        startup_strobes++;
      end
      if (read_ctx) begin
        assert (o_bus_cmd_data && o_bus_data == 4'h0)
        else report_error("read strobe is not a PC_READ data strobe");
        rd_chk <= 1'b1;
        rd_exp <= i_bus_data;
      end
      // configure stall window runs to the reissued PC_READ
      if (!o_bus_cmd_data && o_bus_data == CONFIGURE) begin
        cfg_window <= 1'b1;
      end
      if (!o_bus_cmd_data && o_bus_data == PC_READ) begin
        cfg_window <= 1'b0;
      end
    end else begin
      take_bits(bus_lfsr, 4, v);
      i_bus_data <= v[3:0];
    end
    if (rd_chk) begin
      assert (o_nibble == rd_exp)
      else report_error($sformatf("o_nibble %h, expected %h", o_nibble, rd_exp));
    end
    if (o_bus_done) begin
      done_cnt++;
      done_at = words.size();
    end
    wr_nibl <= wr_data[o_data_ptr[2:0]];
  end

  // reset values
  assert property (@(posedge i_clk) (cmd_RESET_0 && cycles > 1) |->
    (!o_bus_strobe && o_bus_reset && o_stall_alu && o_bus_cmd_data && !o_bus_done
     && o_data_ptr == 0))
  else report_error("outputs not at reset values during reset");

  assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    o_bus_strobe || o_bus_cmd_data)
  else report_error("cmd/data low outside a strobe");

  assert property (@(posedge i_clk) o_bus_strobe |=> !o_bus_strobe)
  else report_error("strobe longer than one cycle");

  assert property (@(posedge i_clk) busy_hold |-> !o_bus_strobe)
  else report_error("strobe while the alu is busy");

  assert property (@(posedge i_clk) cfg_window |-> o_stall_alu)
  else report_error("stall low inside the configure sequence");

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT + 16) begin
      $display("timeout: the bus did not finish the test sequence in time");
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  initial begin
    logic [31:0] v;
    logic [2:0] cnt;
    cmd_RESET_0 = 1'b1;
    req_ctl = '0;
    wr_nibl = '0;
    i_alu_busy = 1'b0;
    i_bus_data = '0;
    for (int i = 0; i < 8; i++) begin
      wr_data[i] = '0;
    end
    repeat (16) @(posedge i_clk);
    cmd_RESET_0 <= 1'b0;

    // start-up slot
    @(posedge i_clk);
    while (o_bus_reset) begin
      @(posedge i_clk);
    end
    repeat (2) @(posedge i_clk);
    assert (startup_strobes == 1 && words.size() == 1)
    else report_error("start-up did not give exactly one strobe");
    assert (!o_stall_alu && !o_bus_reset) else report_error("stall or bus reset stuck high");

    take_bits(stim_lfsr, 20, v);
    run_addr_cmd(LOAD_PC, v[19:0], 1'b1);

    // pc reads around a busy hold
    clear_log();
    read_ctx <= 1'b1;
    req_ctl.read_pc <= 1'b1;
    wait_strobes(4);
    i_alu_busy <= 1'b1;
    repeat (8) @(posedge i_clk);
    busy_hold <= 1'b1;
    repeat (16) @(posedge i_clk);
    busy_hold <= 1'b0;
    i_alu_busy <= 1'b0;
    clear_log();
    wait_strobes(4);
    req_ctl.read_pc <= 1'b0;
    repeat (8) @(posedge i_clk);
    read_ctx <= 1'b0;
    @(posedge i_clk);

    // load_dp then a counted write
    take_bits(stim_lfsr, 20, v);
    run_addr_cmd(LOAD_DP, v[19:0], 1'b0);
    for (int i = 0; i < 8; i++) begin
      take_bits(stim_lfsr, 4, v);
      wr_data[i] = v[3:0];
    end
    take_bits(stim_lfsr, 3, v);
    cnt = v[2:0];
    clear_log();
    done_cnt = 0;
    req_ctl.xfr_cnt <= cnt;
    req_ctl.dp_write <= 1'b1;
    wait_strobes(1);
    req_ctl.dp_write <= 1'b0;
    wait_strobes(int'(cnt) + 3);
    check_word(0, DP_WRITE, 1'b0);
    for (int k = 0; k <= int'(cnt); k++) begin
      check_word(k + 1, wr_data[k], 1'b1);
    end
    check_word(int'(cnt) + 2, PC_READ, 1'b0);
    assert (done_cnt == 1 && done_at == int'(cnt) + 2)
    else report_error("done pulse missing, repeated or misplaced");
    repeat (3) @(posedge i_clk);
    assert (!o_stall_alu) else report_error("stall still high after dp write");

    take_bits(stim_lfsr, 20, v);
    run_addr_cmd(CONFIGURE, v[19:0], 1'b1);

    repeat (4) @(posedge i_clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/saturn_bus_ctrl.sv
// saturn bus controller top, connects phase generator, engines and arbiter
`timescale 1ns/100ps
`default_nettype none

module saturn_bus_ctrl
  import saturn_bus_pkg::*, saturn_core_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 cmd_RESET_0,
  input  core_req_t           i_req,
  input  wire                 i_alu_busy,
  input  wire  [NIBBLE_W-1:0] i_bus_data,
  output logic [NIBBLE_W-1:0] o_bus_data,
  output logic                o_bus_cmd_data,
  output logic                o_bus_strobe,
  output logic                o_bus_reset,
  output logic [NIBBLE_W-1:0] o_nibble,
  output logic [CNT_W-1:0]    o_data_ptr,
  output logic                o_stall_alu,
  output logic                o_bus_done
);

  // slot timing shared by every engine
  bus_phase_t phase;
  logic       bus_up;

  // one request per bus driver
  bus_drive_t startup_drive;
  bus_drive_t cmd_drive;
  bus_drive_t addr_drive;
  bus_drive_t data_drive;

  // sequencer to address loop
  logic       addr_start;
  addr_kind_e addr_kind;
  logic       addr_done;

  // sequencer to data engine
  logic       pc_read_mode;
  logic       dp_write_mode;
  logic       write_done;

  saturn_bus_phase phase_i (
    .i_clk           (i_clk),
    .cmd_RESET_0     (cmd_RESET_0),
    .o_phase         (phase),
    .o_bus_up        (bus_up),
    .o_startup_drive (startup_drive),
    .o_bus_reset     (o_bus_reset)
  );

  saturn_cmd_seq cmd_seq_i (
    .i_clk           (i_clk),
    .cmd_RESET_0     (cmd_RESET_0),
    .i_phase         (phase),
    .i_bus_up        (bus_up),
    .i_req           (i_req),
    .i_addr_done     (addr_done),
    .i_write_done    (write_done),
    .o_cmd_drive     (cmd_drive),
    .o_addr_start    (addr_start),
    .o_addr_kind     (addr_kind),
    .o_pc_read_mode  (pc_read_mode),
    .o_dp_write_mode (dp_write_mode),
    .o_stall_alu     (o_stall_alu)
  );

  saturn_addr_loop addr_loop_i (
    .i_clk        (i_clk),
    .cmd_RESET_0  (cmd_RESET_0),
    .i_phase      (phase),
    .i_addr_start (addr_start),
    .i_addr_kind  (addr_kind),
    .i_address    (i_req.address),
    .o_addr_drive (addr_drive),
    .o_addr_done  (addr_done)
  );

  saturn_data_xfer data_xfer_i (
    .i_clk           (i_clk),
    .cmd_RESET_0     (cmd_RESET_0),
    .i_phase         (phase),
    .i_pc_read_mode  (pc_read_mode),
    .i_dp_write_mode (dp_write_mode),
    .i_read_pc       (i_req.read_pc),
    .i_alu_busy      (i_alu_busy),
    .i_data_nibl     (i_req.data_nibl),
    .i_xfr_cnt       (CNT_W'(i_req.xfr_cnt)),
    .i_bus_data      (i_bus_data),
    .o_data_drive    (data_drive),
    .o_nibble        (o_nibble),
    .o_data_ptr      (o_data_ptr),
    .o_bus_done      (o_bus_done),
    .o_write_done    (write_done)
  );

  saturn_bus_arbiter arbiter_i (
    .i_clk           (i_clk),
    .cmd_RESET_0     (cmd_RESET_0),
    .i_phase         (phase),
    .i_startup_drive (startup_drive),
    .i_cmd_drive     (cmd_drive),
    .i_addr_drive    (addr_drive),
    .i_data_drive    (data_drive),
    .o_bus_data      (o_bus_data),
    .o_bus_cmd_data  (o_bus_cmd_data),
    .o_bus_strobe    (o_bus_strobe)
  );

endmodule

`default_nettype wire

//--- verilog/saturn_bus_arbiter.sv
// bus arbiter, fixed priority pick per slot, word register and phase 1 strobe
`timescale 1ns/100ps
`default_nettype none

module saturn_bus_arbiter
  import saturn_bus_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 cmd_RESET_0,
  input  bus_phase_t          i_phase,
  input  bus_drive_t          i_startup_drive,
  input  bus_drive_t          i_cmd_drive,
  input  bus_drive_t          i_addr_drive,
  input  bus_drive_t          i_data_drive,
  output logic [NIBBLE_W-1:0] o_bus_data,
  output logic                o_bus_cmd_data,
  output logic                o_bus_strobe
);

  bus_drive_t sel;
  bus_word_u  word_q;

  // start-up, then command, then address, then data
  always_comb begin
    sel = i_data_drive;
    if (i_addr_drive.req) begin
      sel = i_addr_drive;
    end
    if (i_cmd_drive.req) begin
      sel = i_cmd_drive;
    end
    if (i_startup_drive.req) begin
      sel = i_startup_drive;
    end
  end

  // strobe covers phase 1 only
  // cmd/data level is back high from phase 2
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      o_bus_strobe   <= 1'b0;
      o_bus_cmd_data <= 1'b1;
    end else if (i_phase == 2'd0 && sel.req) begin
      o_bus_strobe   <= 1'b1;
      o_bus_cmd_data <= sel.cmd_data;
    end else if (i_phase == 2'd1) begin
      o_bus_strobe   <= 1'b0;
      o_bus_cmd_data <= 1'b1;
    end
  end

  // word holds until the next granted slot
  always_ff @(posedge i_clk) begin
    if (i_phase == 2'd0 && sel.req) begin
      word_q <= sel.word;
    end
  end

  assign o_bus_data = word_q.nibl;

endmodule

`default_nettype wire

//--- verilog/saturn_data_xfer.sv
// data engine, pc reads held off by the alu and counted dp writes
`timescale 1ns/100ps
`default_nettype none

module saturn_data_xfer
  import saturn_bus_pkg::*, saturn_core_pkg::*;
(
  input  wire                 i_clk,
  input  wire                 cmd_RESET_0,
  input  bus_phase_t          i_phase,
  input  wire                 i_pc_read_mode,
  input  wire                 i_dp_write_mode,
  input  wire                 i_read_pc,
  input  wire                 i_alu_busy,
  input  wire  [NIBBLE_W-1:0] i_data_nibl,
  input  wire  [CNT_W-1:0]    i_xfr_cnt,
  input  wire  [NIBBLE_W-1:0] i_bus_data,
  output bus_drive_t          o_data_drive,
  output logic [NIBBLE_W-1:0] o_nibble,
  output logic [CNT_W-1:0]    o_data_ptr,
  output logic                o_bus_done,
  output logic                o_write_done
);

  logic req_rd;
  logic req_wr;
  // requests offered at the last phase 0
  logic rd_pend;
  logic wr_pend;

  // no read while the alu is busy
  assign req_rd = i_pc_read_mode && i_read_pc && !i_alu_busy;
  assign req_wr = i_dp_write_mode;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      rd_pend    <= 1'b0;
      wr_pend    <= 1'b0;
      o_data_ptr <= '0;
      o_bus_done <= 1'b0;
    end else begin
      o_bus_done <= 1'b0;
      if (i_phase == 2'd0) begin
        rd_pend <= req_rd;
        wr_pend <= req_wr;
      end
      if (!i_dp_write_mode) begin
        o_data_ptr <= '0;
      end else if (i_phase == 2'd1 && wr_pend) begin
        // last nibble out, done shows in phase 2
        if (o_data_ptr == i_xfr_cnt) begin
          o_bus_done <= 1'b1;
        end else begin
          o_data_ptr <= o_data_ptr + 1'b1;
        end
      end
    end
  end

  // read lost to a new command when the mode dropped at phase 0
  always_ff @(posedge i_clk) begin
    if (i_phase == 2'd1 && rd_pend && i_pc_read_mode) begin
      o_nibble <= i_bus_data;
    end
  end

  // reads put PC_READ on the bus as data
  always_comb begin
    o_data_drive          = '0;
    o_data_drive.req      = req_rd || req_wr;
    o_data_drive.cmd_data = 1'b1;
    if (req_wr) begin
      o_data_drive.word.nibl = i_data_nibl;
    end else begin
      o_data_drive.word.cmd = PC_READ;
    end
  end

  assign o_write_done = o_bus_done;

endmodule

`default_nettype wire

//--- verilog/saturn_addr_loop.sv
// address loop, sends five address nibbles low first after an address command
`timescale 1ns/100ps
`default_nettype none

module saturn_addr_loop
  import saturn_bus_pkg::*, saturn_core_pkg::*;
(
  input  wire               i_clk,
  input  wire               cmd_RESET_0,
  input  bus_phase_t        i_phase,
  input  wire               i_addr_start,
  input  addr_kind_e        i_addr_kind,
  input  wire  [ADDR_W-1:0] i_address,
  output bus_drive_t        o_addr_drive,
  output logic              o_addr_done
);

  logic              run;
  // nibbles already sent
  logic [2:0]        idx;
  // shifts down one nibble per slot
  logic [ADDR_W-1:0] addr_q;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      run         <= 1'b0;
      idx         <= '0;
      o_addr_done <= 1'b0;
    end else begin
      o_addr_done <= 1'b0;
      if (i_addr_start) begin
        run <= 1'b1;
        idx <= '0;
      end else if (run && i_phase == 2'd0) begin
        // arbiter takes the nibble on this edge
        idx <= idx + 1'b1;
        if (idx == 3'(ADDR_NIBBLES - 1)) begin
          run <= 1'b0;
        end
      end else if (!run && idx == 3'(ADDR_NIBBLES)) begin
        // done pulse lands in phase 3 of the last slot
        if (i_phase == 2'd2) begin
          o_addr_done <= (i_addr_kind != KIND_NONE);
        end
        if (i_phase == 2'd3) begin
          idx <= '0;
        end
      end
    end
  end

  // payload, captured with the command
  always_ff @(posedge i_clk) begin
    if (i_addr_start) begin
      addr_q <= i_address;
    end else if (run && i_phase == 2'd0) begin
      addr_q <= addr_q >> NIBBLE_W;
    end
  end

  always_comb begin
    o_addr_drive           = '0;
    o_addr_drive.req       = run;
    o_addr_drive.cmd_data  = 1'b1;
    o_addr_drive.word.nibl = addr_q[NIBBLE_W-1:0];
  end

endmodule

`default_nettype wire

//--- verilog/saturn_cmd_seq.sv
// command sequencer, last command and pointer state, pc_read reissue and alu stall
`timescale 1ns/100ps
`default_nettype none

module saturn_cmd_seq
  import saturn_bus_pkg::*, saturn_core_pkg::*;
(
  input  wire        i_clk,
  input  wire        cmd_RESET_0,
  input  bus_phase_t i_phase,
  input  wire        i_bus_up,
  input  core_req_t  i_req,
  input  wire        i_addr_done,
  input  wire        i_write_done,
  output bus_drive_t o_cmd_drive,
  output logic       o_addr_start,
  output addr_kind_e o_addr_kind,
  output logic       o_pc_read_mode,
  output logic       o_dp_write_mode,
  output logic       o_stall_alu
);

  // S_PCR waits for its slot, S_REL releases the stall after it
  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_DPW, S_PCR, S_REL} seq_state_e;

  seq_state_e state;
  bus_cmd_e   last_cmd;
  // current pointer, 0 is PC and 1 is DP
  logic       ptr_dp;
  logic       stall_q;
  logic       cmd_req;
  bus_cmd_e   cmd_code;
  logic       accept;

  // command word toward the arbiter
  always_comb begin
    cmd_req  = 1'b0;
    cmd_code = PC_READ;
    if (state == S_PCR) begin
      cmd_req = 1'b1;
    end else if (state == S_IDLE && i_bus_up) begin
      // new core requests only while nothing is in flight
      if (i_req.load_pc) begin
        cmd_req  = 1'b1;
        cmd_code = LOAD_PC;
      end else if (i_req.load_dp) begin
        cmd_req  = 1'b1;
        cmd_code = LOAD_DP;
      end else if (i_req.configure) begin
        cmd_req  = 1'b1;
        cmd_code = CONFIGURE;
      end else if (i_req.dp_write && ptr_dp && last_cmd == LOAD_DP) begin
        // writes only right after a LOAD_DP
        cmd_req  = 1'b1;
        cmd_code = DP_WRITE;
      end
    end
    o_cmd_drive          = '0;
    o_cmd_drive.req      = cmd_req;
    o_cmd_drive.cmd_data = 1'b0;
    o_cmd_drive.word.cmd = cmd_code;
  end

  // commands win arbitration once the bus is up
  assign accept       = (state == S_IDLE) && cmd_req && (i_phase == 2'd0);
  assign o_addr_start = accept && (cmd_code != DP_WRITE);

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      state       <= S_IDLE;
      last_cmd    <= PC_READ;
      ptr_dp      <= 1'b0;
      stall_q     <= 1'b1;
      o_addr_kind <= KIND_NONE;
    end else begin
      // start-up slot over, alu may run
      if (!i_bus_up && i_phase == 2'd1) begin
        stall_q <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (accept) begin
            last_cmd <= o_cmd_drive.word.cmd;
            stall_q  <= 1'b1;
            state    <= S_ADDR;
            case (cmd_code)
              LOAD_PC: begin
                o_addr_kind <= KIND_PC;
                ptr_dp      <= 1'b0;
              end
              LOAD_DP: begin
                o_addr_kind <= KIND_DP;
                ptr_dp      <= 1'b1;
              end
              CONFIGURE: o_addr_kind <= KIND_CONFIG;
              default:   state <= S_DPW;
            endcase
          end
        end
        S_ADDR: begin
          if (i_addr_done) begin
            o_addr_kind <= KIND_NONE;
            // LOAD_DP hands the bus back, the others reissue PC_READ
            if (o_addr_kind == KIND_DP) begin
              stall_q <= 1'b0;
              state   <= S_IDLE;
            end else begin
              state <= S_PCR;
            end
          end
        end
        S_DPW: begin
          if (i_write_done) begin
            state <= S_PCR;
          end
        end
        S_PCR: begin
          if (i_phase == 2'd0) begin
            last_cmd <= PC_READ;
            ptr_dp   <= 1'b0;
            stall_q  <= 1'b1;
            state    <= S_REL;
          end
        end
        default: begin
          // unstall in phase 3 of the PC_READ slot
          if (i_phase == 2'd2) begin
            stall_q <= 1'b0;
            state   <= S_IDLE;
          end
        end
      endcase
    end
  end

  assign o_pc_read_mode  = i_bus_up && (state == S_IDLE) && !ptr_dp && (last_cmd == PC_READ);
  assign o_dp_write_mode = (state == S_DPW);
  // LOAD_DP releases in phase 3 of the last address slot
  assign o_stall_alu     = stall_q && !(i_addr_done && o_addr_kind == KIND_DP);

endmodule

`default_nettype wire

//--- verilog/saturn_bus_phase.sv
// phase generator and bus start-up sequencer, one strobe slot out of reset
`timescale 1ns/100ps
`default_nettype none

module saturn_bus_phase
  import saturn_bus_pkg::*;
(
  input  wire        i_clk,
  input  wire        cmd_RESET_0,
  output bus_phase_t o_phase,
  output logic       o_bus_up,
  output bus_drive_t o_startup_drive,
  output logic       o_bus_reset
);

  bus_phase_t phase_q;
  logic       bus_reset_q;

  // free running slot phase, restarts at 0 out of reset
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      phase_q <= '0;
    end else if (phase_q == bus_phase_t'(PHASES - 1)) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // bus reset stays up through phase 1 of the first slot
  // low from phase 2 on, bus then belongs to the engines
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      bus_reset_q <= 1'b1;
    end else if (bus_reset_q && phase_q == 2'd1) begin
      bus_reset_q <= 1'b0;
    end
  end

  // start-up strobe is a data strobe with a zero word
  always_comb begin
    o_startup_drive           = '0;
    o_startup_drive.req       = bus_reset_q;
    o_startup_drive.cmd_data  = 1'b1;
    o_startup_drive.word.nibl = '0;
  end

  assign o_phase     = phase_q;
  assign o_bus_reset = bus_reset_q;
  // engines may only start once the reset slot is over
  assign o_bus_up    = !bus_reset_q;

endmodule

`default_nettype wire

//--- verilog/saturn_core_pkg.sv
// core side request bundle and address command kinds for the bus controller
`default_nettype none

package saturn_core_pkg;

  // saturn addresses are five nibbles
  localparam int ADDR_W = 20;

  // transfer count and data pointer width
  localparam int CNT_W = 4;

  // everything the core asks of the bus controller
  typedef struct packed {
    logic               load_pc;
    logic               load_dp;
    logic               configure;
    logic               dp_write;
    // core is ready to take a pc nibble
    logic               read_pc;
    logic [ADDR_W-1:0]  address;
    // nibble to write while o_data_ptr points at it
    logic [3:0]         data_nibl;
    // number of nibbles to write, minus one
    logic [CNT_W-2:0]   xfr_cnt;
  } core_req_t;

  // which address command the address loop is serving
  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,
    KIND_PC     = 2'd1,
    KIND_DP     = 2'd2,
    KIND_CONFIG = 2'd3
  } addr_kind_e;

endpackage

`default_nettype wire

//--- verilog/saturn_bus_pkg.sv
// saturn nibble bus protocol types, command codes and slot constants
`default_nettype none

package saturn_bus_pkg;

  // one bus word is a single nibble
  localparam int NIBBLE_W = 4;

  // address commands are followed by this many nibbles, low first
  localparam int ADDR_NIBBLES = 5;

  // four i_clk cycles per bus slot
  localparam int PHASES = 4;

  // phase number inside a slot
  typedef logic [1:0] bus_phase_t;

  // bus command codes
  typedef enum logic [NIBBLE_W-1:0] {
    PC_READ   = 4'h0,
    DP_WRITE  = 4'h3,
    LOAD_PC   = 4'h4,
    LOAD_DP   = 4'h5,
    CONFIGURE = 4'h6
  } bus_cmd_e;

  // same four wires, decoded as a command or as raw data
  typedef union packed {
    bus_cmd_e            cmd;
    logic [NIBBLE_W-1:0] nibl;
  } bus_word_u;

  // request from one engine toward the arbiter
  typedef struct packed {
    logic      req;
    // low for a command word, high for data
    logic      cmd_data;
    bus_word_u word;
  } bus_drive_t;

endpackage

`default_nettype wire
